// File: pe_cell.sv
`timescale 1ns/1ps

module pe_cell #(
  parameter int ROW  = 0,
  parameter int COL  = 0,
  parameter int COLS = 10
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  torus_pkg::pe_links_t nbr,
  input  logic                 step_en,
  input  torus_pkg::step_op_t  op,
  input  logic                 wr_en,
  input  torus_pkg::adr_t      wr_adr,
  input  torus_pkg::word_t     wr_dat,
  output torus_pkg::word_t     state
);
  import torus_pkg::*;

  localparam adr_t MY_ADR = adr_t'(ROW * COLS + COL);  // row-major.

  word_t next_val;
  logic  hit;

  assign hit = wr_en && (wr_adr == MY_ADR);

  always_comb begin
    case (op)
      op_shift_east:  next_val = nbr.west;
      op_shift_south: next_val = nbr.north;
      default:        next_val = nbr.north + nbr.east + nbr.south + nbr.west;  // mod 2^16.
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= '0;
    end else if (hit) begin
      state <= wr_dat;
    end else if (step_en) begin
      state <= next_val;
    end
  end

  // the bus slave drops cell writes while the controller is running.
  a_no_wr_in_step: assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_en && step_en)
  ) else $error("pe_cell %0d,%0d: cell write during a step", ROW, COL);

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the torus testbench with verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_torus -Mdir obj_dir -o vtb_torus
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/vtb_torus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// File: sim.f
+incdir+.
torus_pkg.sv
pe_cell.sv
torus_array.sv
step_ctrl.sv
wb_regs.sv
torus_top.sv
tb_torus.sv

// File: step_ctrl.sv
`timescale 1ns/1ps

module step_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  torus_pkg::step_cnt_t  steps,
  input  torus_pkg::step_op_t   op_in,
  output logic                  busy,
  output logic                  step_en,
  output torus_pkg::step_op_t   op
);
  import torus_pkg::*;

  typedef enum logic {
    st_idle,
    st_run
  } state_t;

  state_t    state_q;
  step_cnt_t cnt_q;  // steps left, including the current one.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      op      <= op_shift_east;
    end else begin
      case (state_q)
        st_idle: begin
          if (start && (steps != '0)) begin  // zero-length runs are ignored.
            state_q <= st_run;
            cnt_q   <= steps;
            op      <= op_in;
          end
        end
        st_run: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == step_cnt_t'(1)) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign busy    = (state_q == st_run);
  assign step_en = (cnt_q != '0);

  // counter and state machine must agree on the run length.
  a_en_is_busy: assert property (
    @(posedge clk) disable iff (!rst_n) step_en == busy
  ) else $error("step_ctrl: step_en and busy disagree");

endmodule

// File: tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// xorshift32, state lives in rng_state.
function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  rng_state = x;
  return x;
endfunction

// control register layout: start[15], steps[9:2], op[1:0].
function automatic word_t ctrl_word(input logic start, input int steps, input int op);
  return {start, 5'd0, steps[7:0], op[1:0]};
endfunction

// one step of the whole torus, edges wrap around.
function automatic void apply_step(input step_op_t op);
  word_t nxt [NCELLS];
  int    r;
  int    c;
  int    n;
  int    s;
  int    e;
  int    w;
  for (int i = 0; i < NCELLS; i++) begin
    r = i / COLS;
    c = i % COLS;
    n = ((r + ROWS - 1) % ROWS) * COLS + c;
    s = ((r + 1) % ROWS) * COLS + c;
    e = r * COLS + (c + 1) % COLS;
    w = r * COLS + (c + COLS - 1) % COLS;
    case (op)
      op_shift_east:  nxt[i] = model[w];
      op_shift_south: nxt[i] = model[n];
      default:        nxt[i] = model[n] + model[e] + model[s] + model[w];
    endcase
  end
  model = nxt;
endfunction

task automatic begin_test(input string name);
  cur_test    = name;
  test_checks = 0;
  test_errs   = 0;
endtask

task automatic end_test();
  tests_done++;
  if (test_errs == 0) begin
    $display("test %0d %s: %0d checks ok", tests_done, cur_test, test_checks);
  end else begin
    $display("test %0d %s: %0d checks, %0d errors", tests_done, cur_test, test_checks,
             test_errs);
  end
endtask

task automatic report_problem(input string msg);
  $display("error in test %s: %s", cur_test, msg);
  test_errs++;
  errors++;
endtask

task automatic check_eq(input string what, input word_t exp, input word_t act);
  test_checks++;
  checks++;
  assert (act === exp) else begin
    $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
    test_errs++;
    errors++;
  end
endtask

// classic cycle, driven on the falling edge and held until ack.
task automatic classic_access(input logic we, input adr_t adr, input word_t wdat,
                              output word_t rdat);
  int waited;
  waited = 0;
  rdat   = '0;
  @(negedge clk);
  bus.cyc = 1'b1;
  bus.stb = 1'b1;
  bus.we  = we;
  bus.adr = adr;
  bus.dat = wdat;
  do begin
    @(negedge clk);
    waited++;
  end while (!rsp.ack && (waited < ACK_LIMIT));
  if (rsp.ack) begin
    rdat = rsp.dat;
  end else begin
    report_problem($sformatf("no ack from the DUT for address %0d", adr));
  end
  bus.cyc = 1'b0;
  bus.stb = 1'b0;
  bus.we  = 1'b0;
endtask

task automatic write_word(input adr_t adr, input word_t dat);
  word_t unused;
  classic_access(1'b1, adr, dat, unused);
endtask

task automatic read_word(input adr_t adr, output word_t dat);
  classic_access(1'b0, adr, '0, dat);
endtask

task automatic fill_random();
  word_t v;
  for (int i = 0; i < NCELLS; i++) begin
    v = word_t'(next_rand());
    write_word(adr_t'(i), v);
    model[i] = v;
  end
endtask

task automatic compare_cells();
  word_t rd;
  for (int i = 0; i < NCELLS; i++) begin
    read_word(adr_t'(i), rd);
    check_eq($sformatf("cell %0d", i), model[i], rd);
  end
endtask

task automatic wait_idle();
  word_t st;
  int    polls;
  polls = 0;
  st    = 16'd1;
  while (st[0] && (polls < POLL_LIMIT)) begin
    read_word(ADR_STATUS, st);
    polls++;
  end
  if (st[0]) begin
    report_problem($sformatf("busy still set after %0d status reads", POLL_LIMIT));
  end
endtask

task automatic run_and_compare(input string name, input step_op_t op, input int max_steps);
  int n;
  begin_test(name);
  fill_random();
  n = 1 + int'(next_rand() % max_steps);
  for (int k = 0; k < n; k++) begin
    apply_step(op);
  end
  write_word(ADR_CTRL, ctrl_word(1'b1, n, int'(op)));
  wait_idle();
  compare_cells();
  end_test();
endtask

`endif

// File: tb_torus.sv
`timescale 1ns/1ps

module tb_torus;
  import torus_pkg::*;

  localparam int ROWS        = 10;
  localparam int COLS        = 10;
  localparam int NCELLS      = ROWS * COLS;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 20000;
  localparam int ACK_LIMIT   = 16;   // cycles to wait for ack.
  localparam int POLL_LIMIT  = 400;  // status reads before giving up on busy.

  logic    clk = 1'b0;
  logic    rst_n;
  wb_req_t bus;
  wb_rsp_t rsp;

  word_t       model [NCELLS];  // expected cell contents.
  logic [31:0] rng_state;
  string       cur_test;
  int          test_checks;
  int          test_errs;
  int          checks;
  int          errors;
  int          tests_done;

  torus_top #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .rsp   (rsp)
  );

  always #4 clk = ~clk;

  `include "tb_tasks.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    word_t rd;
    word_t exp;
    word_t wr;
    int    n;
    int    idx;
    int    raw_op;

    rst_n       = 1'b0;
    bus         = '0;
    rng_state   = 32'h30ed;
    checks      = 0;
    errors      = 0;
    tests_done  = 0;
    test_checks = 0;
    test_errs   = 0;
    for (int i = 0; i < NCELLS; i++) begin
      model[i] = '0;  // cells clear on reset.
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // everything starts cleared.
    begin_test("reset");
    check_eq("ack", 16'd0, word_t'(rsp.ack));
    compare_cells();
    read_word(ADR_STATUS, rd);
    check_eq("status", 16'd0, rd);
    end_test();

    begin_test("write_read");
    fill_random();
    compare_cells();
    n      = int'(next_rand() % 256);
    raw_op = int'(next_rand() % 4);
    write_word(ADR_CTRL, ctrl_word(1'b0, n, raw_op));
    read_word(ADR_CTRL, rd);
    exp = ctrl_word(1'b0, n, (raw_op == 3) ? 2 : raw_op);  // illegal op reads as sum.
    check_eq("ctrl", exp, rd);
    read_word(ADR_STATUS, rd);
    check_eq("status without start", 16'd0, rd);
    end_test();

    run_and_compare("shift_east", op_shift_east, 12);
    run_and_compare("shift_south", op_shift_south, 12);
    run_and_compare("sum", op_sum, 4);

    // long run with a dropped write and an ignored second start.
    begin_test("busy_drop");
    fill_random();
    n = 150 + int'(next_rand() % 101);
    for (int k = 0; k < n; k++) begin
      apply_step(op_shift_south);
    end
    idx = int'(next_rand() % NCELLS);
    wr  = ~model[idx];
    write_word(ADR_CTRL, ctrl_word(1'b1, n, int'(op_shift_south)));
    read_word(ADR_STATUS, rd);
    check_eq("status while running", 16'd1, rd);
    write_word(adr_t'(idx), wr);
    write_word(ADR_CTRL, ctrl_word(1'b1, 255, int'(op_sum)));
    read_word(ADR_STATUS, rd);
    check_eq("status after second start", 16'd1, rd);
    wait_idle();
    compare_cells();
    read_word(adr_t'(idx), rd);
    assert (rd !== wr) else begin
      report_problem($sformatf("cell %0d kept the value %h written while busy", idx, wr));
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: torus_array.sv
`timescale 1ns/1ps

module torus_array #(
  parameter int ROWS = 10,
  parameter int COLS = 10
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                step_en,
  input  torus_pkg::step_op_t                 op,
  input  logic                                wr_en,
  input  torus_pkg::adr_t                     wr_adr,
  input  torus_pkg::word_t                    wr_dat,
  output torus_pkg::word_t [ROWS*COLS-1:0]    cell_data
);
  import torus_pkg::*;

  if (ROWS * COLS > MAX_CELLS) begin : g_size_chk
    $error("torus_array: %0d cells exceed the bus window", ROWS * COLS);
  end

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    for (genvar c = 0; c < COLS; c++) begin : g_col
      // neighbour indices, edges wrap to the opposite side.
      localparam int IDX   = r * COLS + c;
      localparam int N_IDX = ((r + ROWS - 1) % ROWS) * COLS + c;
      localparam int S_IDX = ((r + 1) % ROWS) * COLS + c;
      localparam int E_IDX = r * COLS + (c + 1) % COLS;
      localparam int W_IDX = r * COLS + (c + COLS - 1) % COLS;

      pe_links_t links;

      assign links.north = cell_data[N_IDX];
      assign links.east  = cell_data[E_IDX];
      assign links.south = cell_data[S_IDX];
      assign links.west  = cell_data[W_IDX];

      pe_cell #(
        .ROW  (r),
        .COL  (c),
        .COLS (COLS)
      ) u_pe (
        .clk     (clk),
        .rst_n   (rst_n),
        .nbr     (links),
        .step_en (step_en),
        .op      (op),
        .wr_en   (wr_en),
        .wr_adr  (wr_adr),
        .wr_dat  (wr_dat),
        .state   (cell_data[IDX])
      );
    end
  end

endmodule

// File: torus_pkg.sv
package torus_pkg;

  typedef logic [15:0] word_t;      // cell value and bus data.
  typedef logic [7:0]  adr_t;       // wishbone word address.
  typedef logic [7:0]  step_cnt_t;

  // operation applied by every cell on a step.
  typedef enum logic [1:0] {
    op_shift_east  = 2'd0,  // take the west word.
    op_shift_south = 2'd1,  // take the north word.
    op_sum         = 2'd2   // sum of all four neighbours.
  } step_op_t;

  // neighbour words arriving at one cell.
  typedef struct packed {
    word_t north;
    word_t east;
    word_t south;
    word_t west;
  } pe_links_t;

  typedef struct packed {
    logic       start;  // write only, reads back as 0.
    logic [4:0] rsvd;
    step_cnt_t  steps;
    step_op_t   op;
  } ctrl_reg_t;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    adr_t  adr;
    word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // register map.
  localparam adr_t        ADR_CTRL   = 8'd128;
  localparam adr_t        ADR_STATUS = 8'd129;
  localparam int unsigned MAX_CELLS  = 128;  // cell window below ADR_CTRL.

endpackage

// File: torus_top.sv
`timescale 1ns/1ps

module torus_top #(
  parameter int ROWS = 10,
  parameter int COLS = 10
) (
  input  logic               clk,
  input  logic               rst_n,
  input  torus_pkg::wb_req_t bus,
  output torus_pkg::wb_rsp_t rsp
);
  import torus_pkg::*;

  logic                        start;
  logic                        busy;
  logic                        step_en;
  logic                        cell_wr;
  step_cnt_t                   steps;
  step_op_t                    op_req;  // op written with the start.
  step_op_t                    op_run;  // op latched for the run.
  adr_t                        wr_adr;
  word_t                       wr_dat;
  word_t [ROWS*COLS-1:0]       cell_data;

  wb_regs #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .busy      (busy),
    .cell_data (cell_data),
    .rsp       (rsp),
    .start     (start),
    .steps     (steps),
    .op        (op_req),
    .cell_wr   (cell_wr),
    .wr_adr    (wr_adr),
    .wr_dat    (wr_dat)
  );

  step_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .steps   (steps),
    .op_in   (op_req),
    .busy    (busy),
    .step_en (step_en),
    .op      (op_run)
  );

  torus_array #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .step_en   (step_en),
    .op        (op_run),
    .wr_en     (cell_wr),
    .wr_adr    (wr_adr),
    .wr_dat    (wr_dat),
    .cell_data (cell_data)
  );

endmodule

// File: wb_regs.sv
`timescale 1ns/1ps

module wb_regs #(
  parameter int ROWS = 10,
  parameter int COLS = 10
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  torus_pkg::wb_req_t                bus,
  input  logic                              busy,
  input  torus_pkg::word_t [ROWS*COLS-1:0]  cell_data,
  output torus_pkg::wb_rsp_t                rsp,
  output logic                              start,
  output torus_pkg::step_cnt_t              steps,
  output torus_pkg::step_op_t               op,
  output logic                              cell_wr,
  output torus_pkg::adr_t                   wr_adr,
  output torus_pkg::word_t                  wr_dat
);
  import torus_pkg::*;

  localparam int NCELLS = ROWS * COLS;
  localparam int IDX_W  = $clog2(NCELLS);

  logic      req;
  logic      wr_req;
  logic      ack_q;
  word_t     rd_mux;
  word_t     rd_dat_q;
  ctrl_reg_t wr_ctrl;
  ctrl_reg_t ctrl_q;

  assign req     = bus.cyc && bus.stb && !ack_q;  // first edge of each cycle.
  assign wr_req  = req && bus.we;
  assign wr_ctrl = ctrl_reg_t'(bus.dat);

  // run request goes straight to the controller with the start pulse.
  assign steps = wr_ctrl.steps;
  assign op    = (bus.dat[1:0] == 2'b11) ? op_sum : step_op_t'(bus.dat[1:0]);
  assign start = wr_req && (bus.adr == ADR_CTRL) && wr_ctrl.start;

  // cells decode their own index, writes are lost while a run is active.
  assign cell_wr = wr_req && (bus.adr < MAX_CELLS) && !busy;
  assign wr_adr  = bus.adr;
  assign wr_dat  = bus.dat;

  always_comb begin
    rd_mux = '0;
    if (bus.adr < NCELLS) begin
      rd_mux = cell_data[bus.adr[IDX_W-1:0]];
    end else if (bus.adr == ADR_STATUS) begin
      rd_mux = word_t'(busy);
    end else if (bus.adr == ADR_CTRL) begin
      rd_mux = word_t'(ctrl_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q  <= 1'b0;
      ctrl_q <= '0;
    end else begin
      ack_q <= req;
      if (wr_req && (bus.adr == ADR_CTRL)) begin
        ctrl_q.start <= 1'b0;  // never stored.
        ctrl_q.rsvd  <= '0;
        ctrl_q.steps <= wr_ctrl.steps;
        ctrl_q.op    <= op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rd_dat_q <= rd_mux;
    end
  end

  assign rsp.ack = ack_q;
  assign rsp.dat = rd_dat_q;

endmodule
